/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge by the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fpga_top -f tb.f \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_fpga_top > sim.log 2>&1 ; cat sim.log

grep -qx "TEST OK" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

/* src/fpga_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fpga_top import lcd_pkg::*; #(
  parameter int BOX_SIZE        = 8,
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  logic        hwclk,
  input  logic        reset,
  input  logic [20:0] pb,
  output logic [7:0]  left,
  output logic [7:0]  right,
  output logic [7:0]  ss7,
  output logic [7:0]  ss6,
  output logic [7:0]  ss5,
  output logic [7:0]  ss4,
  output logic [7:0]  ss3,
  output logic [7:0]  ss2,
  output logic [7:0]  ss1,
  output logic [7:0]  ss0,
  output logic        red,
  output logic        green,
  output logic        blue
);

  logic                         touch_pulse;
  logic [15:0]                  touch_count;
  logic [15:0]                  bytes_written;
  logic                         wrx, rdx, csx, dcx;
  // heartbeat divider
  logic [1:0]                   div_cnt;
  logic                         heartbeat;
  logic [NUM_DIGITS-1:0][3:0]   digit_nibble;
  logic [NUM_DIGITS-1:0][7:0]   digit_seg;

  lcd_write_if wr_bus ();

  // touch interrupt on pb[2], active low
  touch_irq_filter #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) u_irq_filter (
    .hwclk      (hwclk),
    .reset      (reset),
    .irq_n      (pb[2]),
    .touch_pulse(touch_pulse)
  );

  lcd_frame_sequencer #(
    .BOX_SIZE(BOX_SIZE)
  ) u_sequencer (
    .hwclk        (hwclk),
    .reset        (reset),
    .touch_pulse  (touch_pulse),
    .wr           (wr_bus.source),
    .touch_count  (touch_count),
    .bytes_written(bytes_written)
  );

  lcd_bus_writer u_bus_writer (
    .hwclk   (hwclk),
    .reset   (reset),
    .wr      (wr_bus.sink),
    .lcd_data(right),
    .wrx     (wrx),
    .rdx     (rdx),
    .csx     (csx),
    .dcx     (dcx)
  );

  // panel strobes on the low nibble of left
  assign left  = {4'b0000, wrx, rdx, csx, dcx};
  assign red   = heartbeat;
  assign green = 1'b0;
  assign blue  = 1'b0;

  // toggles every third clock
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      heartbeat <= 1'b0;
      div_cnt   <= '0;
    end else if (div_cnt > 2'd1) begin
      heartbeat <= !heartbeat;
      div_cnt   <= '0;
    end else begin
      div_cnt <= div_cnt + 2'd1;
    end
  end

  // digit 7 gets the top nibble of touch_count
  assign digit_nibble = {touch_count, bytes_written};

  for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
    hex_digit_decoder u_decoder (
      .nibble  (digit_nibble[i]),
      .segments(digit_seg[i])
    );
  end

  assign ss7 = digit_seg[7];
  assign ss6 = digit_seg[6];
  assign ss5 = digit_seg[5];
  assign ss4 = digit_seg[4];
  assign ss3 = digit_seg[3];
  assign ss2 = digit_seg[2];
  assign ss1 = digit_seg[1];
  assign ss0 = digit_seg[0];

endmodule

`default_nettype wire

/* src/hex_digit_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module hex_digit_decoder (
  input  logic [3:0] nibble,
  output logic [7:0] segments
);

  // segment bits {dp, g, f, e, d, c, b, a}, lit when high
  logic [6:0] seg_gfedcba;

  always_comb begin
    case (nibble)
      4'h0:    seg_gfedcba = 7'b0111111;
      4'h1:    seg_gfedcba = 7'b0000110;
      4'h2:    seg_gfedcba = 7'b1011011;
      4'h3:    seg_gfedcba = 7'b1001111;
      4'h4:    seg_gfedcba = 7'b1100110;
      4'h5:    seg_gfedcba = 7'b1101101;
      4'h6:    seg_gfedcba = 7'b1111101;
      4'h7:    seg_gfedcba = 7'b0000111;
      4'h8:    seg_gfedcba = 7'b1111111;
      4'h9:    seg_gfedcba = 7'b1101111;
      4'hA:    seg_gfedcba = 7'b1110111;
      // lower case b and d
      4'hB:    seg_gfedcba = 7'b1111100;
      4'hC:    seg_gfedcba = 7'b0111001;
      4'hD:    seg_gfedcba = 7'b1011110;
      4'hE:    seg_gfedcba = 7'b1111001;
      default: seg_gfedcba = 7'b1110001;
    endcase
  end

  // decimal point stays dark
  assign segments = {1'b0, seg_gfedcba};

endmodule

`default_nettype wire

/* src/lcd_bus_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_writer import lcd_pkg::*; (
  input  logic       hwclk,
  input  logic       reset,
  lcd_write_if.sink  wr,
  output logic [7:0] lcd_data,
  output logic       wrx,
  output logic       rdx,
  output logic       csx,
  output logic       dcx
);

  // byte on the pins, held through the wrx rise
  lcd_byte_t out_q;
  // byte on the pins closes the square
  logic      last_q;
  // csx goes high on the next edge
  logic      close_q;
  logic      take;

  // busy for exactly the wrx low cycle
  assign wr.busy = !wrx;
  assign take    = wr.valid && !wr.busy;

  assign lcd_data = out_q.data;
  assign dcx      = out_q.dcx;
  // read path unused
  assign rdx      = 1'b1;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      out_q   <= '0;
      wrx     <= 1'b1;
      csx     <= 1'b1;
      last_q  <= 1'b0;
      close_q <= 1'b0;
    end else if (take) begin
      // new byte, strobe low for one cycle
      out_q   <= wr.wr_byte;
      wrx     <= 1'b0;
      csx     <= 1'b0;
      last_q  <= wr.last;
      close_q <= 1'b0;
    end else if (!wrx) begin
      // panel latches on this rise
      wrx     <= 1'b1;
      close_q <= last_q;
    end else if (close_q) begin
      // deselect one cycle after the final rise
      csx     <= 1'b1;
      close_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/lcd_frame_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_frame_sequencer import lcd_pkg::*; #(
  parameter int BOX_SIZE = 8
) (
  input  logic        hwclk,
  input  logic        reset,
  input  logic        touch_pulse,
  lcd_write_if.source wr,
  output logic [15:0] touch_count,
  output logic [15:0] bytes_written
);

  // two bytes per rgb565 pixel
  localparam int PIX_BYTES = 2 * BOX_SIZE * BOX_SIZE;
  localparam int PIX_W     = $clog2(PIX_BYTES);

  typedef enum logic [2:0] {
    S_IDLE,
    S_CASET,
    S_PASET,
    S_RAMWR,
    S_PIXEL
  } seq_state_t;

  seq_state_t       state;
  // byte within an address phase, 0 is the command
  logic [2:0]       sub_cnt;
  logic [PIX_W-1:0] pix_cnt;
  // square index, only the low 6 bits place the square
  logic [5:0]       sq_idx;
  logic             take;
  logic             pix_last;
  logic [15:0]      x0, x1, y0, y1;
  logic [15:0]      colour;

  // picks one address byte, start then end, high first
  function automatic logic [7:0] addr_byte(
    input logic [15:0] start_a,
    input logic [15:0] end_a,
    input logic [2:0]  sel
  );
    logic [7:0] b;
    case (sel)
      3'd1:    b = start_a[15:8];
      3'd2:    b = start_a[7:0];
      3'd3:    b = end_a[15:8];
      default: b = end_a[7:0];
    endcase
    return b;
  endfunction

  assign take     = wr.valid && !wr.busy;
  assign pix_last = (pix_cnt == PIX_W'(PIX_BYTES - 1));

  // 8x8 grid of squares, column first
  assign x0     = 16'(sq_idx[2:0]) * 16'(BOX_SIZE);
  assign y0     = 16'(sq_idx[5:3]) * 16'(BOX_SIZE);
  assign x1     = x0 + 16'(BOX_SIZE - 1);
  assign y1     = y0 + 16'(BOX_SIZE - 1);
  assign colour = PALETTE[sq_idx[1:0]];

  // state only moves on an accepted byte, so these stay put under busy
  assign wr.valid = (state != S_IDLE);
  assign wr.last  = (state == S_PIXEL) && pix_last;

  always_comb begin
    wr.wr_byte = '{dcx: DCX_DATA, data: 8'h00};
    case (state)
      S_CASET: begin
        if (sub_cnt == 3'd0) begin
          wr.wr_byte = '{dcx: DCX_CMD, data: CMD_CASET};
        end else begin
          wr.wr_byte.data = addr_byte(x0, x1, sub_cnt);
        end
      end
      S_PASET: begin
        if (sub_cnt == 3'd0) begin
          wr.wr_byte = '{dcx: DCX_CMD, data: CMD_PASET};
        end else begin
          wr.wr_byte.data = addr_byte(y0, y1, sub_cnt);
        end
      end
      S_RAMWR: begin
        wr.wr_byte = '{dcx: DCX_CMD, data: CMD_RAMWR};
      end
      S_PIXEL: begin
        // even count is the high colour byte
        wr.wr_byte.data = pix_cnt[0] ? colour[7:0] : colour[15:8];
      end
      default: begin
        wr.wr_byte = '{dcx: DCX_DATA, data: 8'h00};
      end
    endcase
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state         <= S_IDLE;
      sub_cnt       <= '0;
      pix_cnt       <= '0;
      sq_idx        <= '0;
      touch_count   <= '0;
      bytes_written <= '0;
    end else begin
      if (take) begin
        bytes_written <= bytes_written + 16'd1;
      end
      case (state)
        S_IDLE: begin
          // touches outside idle fall through and are lost
          if (touch_pulse) begin
            state       <= S_CASET;
            sub_cnt     <= '0;
            pix_cnt     <= '0;
            sq_idx      <= touch_count[5:0];
            touch_count <= touch_count + 16'd1;
          end
        end
        S_CASET: begin
          if (take) begin
            sub_cnt <= (sub_cnt == 3'd4) ? 3'd0 : sub_cnt + 3'd1;
            if (sub_cnt == 3'd4) begin
              state <= S_PASET;
            end
          end
        end
        S_PASET: begin
          if (take) begin
            sub_cnt <= (sub_cnt == 3'd4) ? 3'd0 : sub_cnt + 3'd1;
            if (sub_cnt == 3'd4) begin
              state <= S_RAMWR;
            end
          end
        end
        S_RAMWR: begin
          if (take) begin
            state <= S_PIXEL;
          end
        end
        S_PIXEL: begin
          if (take) begin
            if (pix_last) begin
              state <= S_IDLE;
            end else begin
              pix_cnt <= pix_cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

  // one byte on the 8080 write bus
  // dcx low marks a command, high marks data
  typedef struct packed {
    logic       dcx;
    logic [7:0] data;
  } lcd_byte_t;

  localparam logic DCX_CMD  = 1'b0;
  localparam logic DCX_DATA = 1'b1;

  // panel command codes
  // column address set
  localparam logic [7:0] CMD_CASET = 8'h2A;
  // page address set
  localparam logic [7:0] CMD_PASET = 8'h2B;
  // memory write, pixel bytes follow
  localparam logic [7:0] CMD_RAMWR = 8'h2C;

  // rgb565 colours, picked by touch count mod 4
  // index 0 red, 1 green, 2 blue, 3 yellow
  localparam logic [3:0][15:0] PALETTE = {
    16'hFFE0,
    16'h001F,
    16'h07E0,
    16'hF800
  };

  // seven-segment digits on the board
  localparam int NUM_DIGITS = 8;

endpackage

`default_nettype wire

/* src/lcd_write_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface lcd_write_if import lcd_pkg::*;;

  // byte offered by the sequencer
  logic      valid;
  lcd_byte_t wr_byte;
  // high with the final byte of a square
  logic      last;
  // writer still strobing the previous byte
  logic      busy;

  // byte moves on a rising edge with valid high and busy low
  modport source (
    output valid,
    output wr_byte,
    output last,
    input  busy
  );

  modport sink (
    input  valid,
    input  wr_byte,
    input  last,
    output busy
  );

endinterface

`default_nettype wire

/* src/touch_irq_filter.sv */
`timescale 1ns/100ps
`default_nettype none

module touch_irq_filter #(
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  logic hwclk,
  input  logic reset,
  input  logic irq_n,
  output logic touch_pulse
);

  localparam int HOLD_W = $clog2(DEBOUNCE_CYCLES + 1);

  // two-flop synchronizer, idles high
  logic [1:0]        irq_sync;
  // previous synchronized level for edge detect
  logic              irq_prev;
  logic              irq_fall;
  // hold-off counter, nonzero blocks new pulses
  logic [HOLD_W-1:0] hold_cnt;

  assign irq_fall = irq_prev && !irq_sync[1];

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      irq_sync    <= 2'b11;
      irq_prev    <= 1'b1;
      hold_cnt    <= '0;
      touch_pulse <= 1'b0;
    end else begin
      irq_sync <= {irq_sync[0], irq_n};
      irq_prev <= irq_sync[1];
      // accept a fall only once the hold-off has run out
      if (irq_fall && hold_cnt == '0) begin
        touch_pulse <= 1'b1;
        hold_cnt    <= HOLD_W'(DEBOUNCE_CYCLES);
      end else begin
        touch_pulse <= 1'b0;
        if (hold_cnt != '0) begin
          hold_cnt <= hold_cnt - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb.f */
src/lcd_pkg.sv
src/lcd_write_if.sv
src/touch_irq_filter.sv
src/lcd_frame_sequencer.sv
src/lcd_bus_writer.sv
src/hex_digit_decoder.sv
src/fpga_top.sv
verification/fpga_top_assertions.sv
verification/tb_fpga_top.sv

/* verification/fpga_top_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module fpga_top_assertions (
  input logic       hwclk,
  input logic       reset,
  input logic       wrx,
  input logic       rdx,
  input logic       csx,
  input logic       dcx,
  input logic [7:0] lcd_data
);

  // strobe low lasts a single cycle
  wrx_single_low: assert property (
    @(posedge hwclk) disable iff (reset) !wrx |=> wrx
  ) else $error("wrx stayed low for two consecutive cycles");

  // panel latches on the rise, bus must not move there
  data_stable_at_rise: assert property (
    @(posedge hwclk) disable iff (reset) $rose(wrx) |-> ($stable(lcd_data) && $stable(dcx))
  ) else $error("data or dcx changed across the wrx rise");

  // chip select covers every strobe
  csx_covers_wrx: assert property (
    @(posedge hwclk) disable iff (reset) !wrx |-> !csx
  ) else $error("wrx low while csx is high");

  // read strobe never used
  rdx_idle: assert property (
    @(posedge hwclk) disable iff (reset) rdx
  ) else $error("rdx went low");

endmodule

// hooked onto the writer inside the board top
bind lcd_bus_writer fpga_top_assertions u_bus_checks (
  .hwclk   (hwclk),
  .reset   (reset),
  .wrx     (wrx),
  .rdx     (rdx),
  .csx     (csx),
  .dcx     (dcx),
  .lcd_data(lcd_data)
);

`default_nettype wire

/* verification/tb_fpga_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_fpga_top import lcd_pkg::*;;

  localparam int BOX_SIZE        = 4;
  localparam int DEBOUNCE_CYCLES = 16;
  // 3 commands, 8 address bytes, then two bytes per pixel
  localparam int SQ_BYTES        = 11 + 2 * BOX_SIZE * BOX_SIZE;
  // enough squares to wrap the 8x8 grid once
  localparam int NUM_TOUCHES     = 66;
  localparam int PIN_LATENCY     = 5;
  localparam int START_TIMEOUT   = 20;
  localparam int SQUARE_TIMEOUT  = 2 * SQ_BYTES + 40;
  localparam int CSX_TIMEOUT     = 4;
  // gfedcba, lit when high, dp dark
  localparam logic [7:0] SEG_TABLE [16] = '{
    8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
    8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71
  };

  logic        hwclk;
  logic        reset;
  logic [20:0] pb;
  logic [7:0]  left, right;
  logic [7:0]  ss7, ss6, ss5, ss4, ss3, ss2, ss1, ss0;
  logic        red, green, blue;
  logic        wrx_pin, rdx_pin, csx_pin, dcx_pin;

  int          value_errors;
  int          other_errors;
  // monitor position in the expected stream
  int          mon_square;
  int          mon_index;
  int          mon_count;
  lcd_byte_t   mon_byte;
  logic [15:0] lfsr_state;
  // rising edges since reset for the heartbeat model
  int          hb_edges;

  fpga_top #(
    .BOX_SIZE       (BOX_SIZE),
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) dut0 (
    .hwclk(hwclk),
    .reset(reset),
    .pb   (pb),
    .left (left),
    .right(right),
    .ss7  (ss7),
    .ss6  (ss6),
    .ss5  (ss5),
    .ss4  (ss4),
    .ss3  (ss3),
    .ss2  (ss2),
    .ss1  (ss1),
    .ss0  (ss0),
    .red  (red),
    .green(green),
    .blue (blue)
  );

  // strobes sit on left[3:0]
  assign wrx_pin = left[3];
  assign rdx_pin = left[2];
  assign csx_pin = left[1];
  assign dcx_pin = left[0];

  initial begin
    hwclk = 1'b0;
    forever begin
      #5;
      hwclk = !hwclk;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic random_bits(input int n, output int value);
    value = 0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  // byte i of square k
  function automatic lcd_byte_t expected_byte(input int k, input int i);
    logic [15:0] x0, y0, x1, y1;
    logic [15:0] start_a, end_a, colour;
    lcd_byte_t   b;
    x0 = 16'((k % 8) * BOX_SIZE);
    y0 = 16'(((k / 8) % 8) * BOX_SIZE);
    x1 = x0 + 16'(BOX_SIZE - 1);
    y1 = y0 + 16'(BOX_SIZE - 1);
    colour = PALETTE[k % 4];
    if (i == 0 || i == 5 || i == 10) begin
      b.dcx = DCX_CMD;
      b.data = (i == 0) ? CMD_CASET : (i == 5) ? CMD_PASET : CMD_RAMWR;
    end else if (i < 10) begin
      // columns first, then pages
      b.dcx = DCX_DATA;
      start_a = (i < 5) ? x0 : y0;
      end_a = (i < 5) ? x1 : y1;
      case ((i - 1) % 5)
        0:       b.data = start_a[15:8];
        1:       b.data = start_a[7:0];
        2:       b.data = end_a[15:8];
        default: b.data = end_a[7:0];
      endcase
    end else begin
      // high colour byte first
      b.dcx = DCX_DATA;
      b.data = ((i - 11) % 2 == 0) ? colour[15:8] : colour[7:0];
    end
    return b;
  endfunction

  task automatic check_byte(input lcd_byte_t got, input lcd_byte_t exp, input int k,
                            input int i);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %0t: square %0d byte %0d got dcx=%b data=%h, expected dcx=%b data=%h",
               $time, k, i, got.dcx, got.data, exp.dcx, exp.data);
    end
  endtask

  task automatic check_segments(input logic [7:0] got, input logic [7:0] exp,
                                input string what);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %0t: %s shows %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pin(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      value_errors++;
      $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic end_run();
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string why);
    other_errors++;
    $display("timeout at %0t: %s", $time, why);
  endtask

  // monitor, panel latches on the wrx rise
  always @(posedge wrx_pin) begin
    if (!reset) begin
      mon_byte.dcx = dcx_pin;
      mon_byte.data = right;
      check_byte(mon_byte, expected_byte(mon_square, mon_index), mon_square, mon_index);
      mon_count++;
      if (mon_index == SQ_BYTES - 1) begin
        mon_index = 0;
        mon_square++;
      end else begin
        mon_index++;
      end
    end
  end

  // red flips on every third rising edge after reset
  always @(posedge hwclk) begin
    if (reset) begin
      hb_edges = 0;
    end else begin
      hb_edges++;
    end
  end

  // heartbeat and the idle board pins
  always @(negedge hwclk) begin
    if (!reset) begin
      check_pin(red, (hb_edges / 3) % 2 == 1, "red heartbeat");
      check_pin(green, 1'b0, "green");
      check_pin(blue, 1'b0, "blue");
      check_pin(|left[7:4], 1'b0, "unused left bits");
    end
  end

  // csx must stay high until the first strobe
  task automatic wait_write_start(output int cycles, output bit ok);
    cycles = 0;
    while (wrx_pin && cycles <= START_TIMEOUT) begin
      check_pin(csx_pin, 1'b1, "csx before first write");
      @(negedge hwclk);
      cycles++;
    end
    ok = !wrx_pin;
    if (!ok) begin
      report_timeout("no wrx fall after a touch");
    end
  endtask

  task automatic wait_byte_index(input int k, input int idx, output bit ok);
    int cycles;
    cycles = 0;
    while (mon_square == k && mon_index < idx && cycles <= SQUARE_TIMEOUT) begin
      @(negedge hwclk);
      cycles++;
    end
    ok = !(mon_square == k && mon_index < idx);
    if (!ok) begin
      report_timeout("square stalled before its last pixel bytes");
    end
  endtask

  task automatic wait_square_done(input int k, output bit ok);
    int cycles;
    cycles = 0;
    while (mon_square <= k && cycles <= SQUARE_TIMEOUT) begin
      @(negedge hwclk);
      cycles++;
    end
    ok = (mon_square > k);
    if (!ok) begin
      report_timeout("square did not complete on the bus");
    end
  endtask

  task automatic wait_csx_high(output bit ok);
    int cycles;
    cycles = 0;
    while (!csx_pin && cycles <= CSX_TIMEOUT) begin
      @(negedge hwclk);
      cycles++;
    end
    ok = (csx_pin === 1'b1);
    if (!ok) begin
      report_timeout("csx did not rise after the last byte");
    end
  endtask

  // bus must stay quiet between squares
  task automatic idle_gap(input int n);
    repeat (n) begin
      @(negedge hwclk);
      check_pin(csx_pin, 1'b1, "csx between squares");
      check_pin(wrx_pin, 1'b1, "wrx between squares");
    end
  endtask

  // pin low for n cycles, starting on this falling edge
  task automatic pulse_touch_pin(input int n);
    pb[2] = 1'b0;
    repeat (n) @(negedge hwclk);
    pb[2] = 1'b1;
  endtask

  task automatic check_digits(input logic [15:0] touches, input logic [15:0] nbytes);
    check_segments(ss7, SEG_TABLE[touches[15:12]], "ss7");
    check_segments(ss6, SEG_TABLE[touches[11:8]], "ss6");
    check_segments(ss5, SEG_TABLE[touches[7:4]], "ss5");
    check_segments(ss4, SEG_TABLE[touches[3:0]], "ss4");
    check_segments(ss3, SEG_TABLE[nbytes[15:12]], "ss3");
    check_segments(ss2, SEG_TABLE[nbytes[11:8]], "ss2");
    check_segments(ss1, SEG_TABLE[nbytes[7:4]], "ss1");
    check_segments(ss0, SEG_TABLE[nbytes[3:0]], "ss0");
  endtask

  // extra 1 touches late in the square and bounces after it
  // extra 2 touches again mid square
  task automatic paint_square(input int k, input int extra, output bit ok);
    int latency;
    @(negedge hwclk);
    pb[2] = 1'b0;
    wait_write_start(latency, ok);
    if (ok) begin
      check_cycles(latency, PIN_LATENCY, "pin to first wrx fall");
      @(negedge hwclk);
      pb[2] = 1'b1;
      if (extra == 1) begin
        // dropped by the busy sequencer yet restarts the hold-off
        wait_byte_index(k, SQ_BYTES - 4, ok);
        if (ok) begin
          pulse_touch_pin(4);
        end
      end else if (extra == 2) begin
        // hold-off over, square still painting
        repeat (DEBOUNCE_CYCLES + 4) @(negedge hwclk);
        pulse_touch_pin(4);
      end
    end
    if (ok) begin
      wait_square_done(k, ok);
    end
    if (ok) begin
      wait_csx_high(ok);
    end
    if (ok && extra == 1) begin
      // bounce on an idle bus, still inside that hold-off
      pulse_touch_pin(2);
    end
  endtask

  initial begin
    int gap;
    int extra;
    bit ok;
    reset = 1'b1;
    // pb[2] idles high
    pb = 21'h000004;
    value_errors = 0;
    other_errors = 0;
    mon_square = 0;
    mon_index = 0;
    mon_count = 0;
    lfsr_state = 16'd16;
    ok = 1'b1;
    repeat (4) @(negedge hwclk);
    reset = 1'b0;
    @(negedge hwclk);
    check_pin(csx_pin, 1'b1, "csx after reset");
    check_pin(wrx_pin, 1'b1, "wrx after reset");
    check_pin(rdx_pin, 1'b1, "rdx after reset");
    check_pin(dcx_pin, 1'b0, "dcx after reset");
    check_digits(16'd0, 16'd0);
    for (int t = 0; t < NUM_TOUCHES && ok; t++) begin
      extra = (t % 8 == 1) ? 1 : (t % 8 == 2) ? 2 : 0;
      paint_square(t, extra, ok);
      if (ok) begin
        random_bits(4, gap);
        idle_gap(DEBOUNCE_CYCLES + gap);
      end
    end
    if (ok) begin
      check_cycles(mon_square, NUM_TOUCHES, "squares seen on the bus");
      check_digits(16'(NUM_TOUCHES), 16'(mon_count));
    end
    end_run();
  end

endmodule

`default_nettype wire
